// File: files.f
+incdir+verif
verilog/lc3IsaPkg.sv
verilog/lc3CtrlPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/lc3Core.sv
verif/lc3CoreTb.sv

// File: Makefile
# Verilator flow for the LC-3 core testbench
VERILATOR ?= verilator
TOP       ?= lc3CoreTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/lc3RefModel.svh
`ifndef LC3_REF_MODEL_SVH
`define LC3_REF_MODEL_SVH

// ----------------------------------------------------------
// Instruction-level model of the supported ISA
// ----------------------------------------------------------

// One visible event, either a store or an LED change
typedef struct packed {
    logic  isLed;
    word_t addr;
    word_t data;
} expEvent_t;

word_t      refMem [0:65535];
word_t      refRegs [8];
logic [2:0] refCc;
ledVal_t    refLed;
expEvent_t  expQ [$];

function automatic word_t sext(input word_t v, input int bits);
    word_t mask;
    mask = (16'd1 << bits) - 16'd1;
    if (v[bits-1]) begin
        return v | ~mask;
    end
    return v & mask;
endfunction

// N, Z, P from the sign of a result
function automatic void setCc(input word_t v);
    refCc = {v[15], v == 16'd0, !v[15] && (v != 16'd0)};
endfunction

task automatic runModel(input word_t startPc, input word_t stopPc, output bit reached);
    word_t     pc;
    word_t     inst;
    word_t     val;
    word_t     ea;
    expEvent_t ev;
    int        steps;
    pc = startPc;
    refCc = 3'b000;
    refLed = '0;
    steps = 0;
    for (int i = 0; i < 8; i++) begin
        refRegs[i] = '0;
    end
    while (pc != stopPc && steps < 1000) begin
        inst = refMem[pc];
        pc = pc + 16'd1;
        steps++;
        case (inst[15:12])
            4'b0001, 4'b0101: begin
                val = inst[5] ? sext(inst, 5) : refRegs[inst[2:0]];
                if (inst[15:12] == 4'b0001) begin
                    val = refRegs[inst[8:6]] + val;
                end else begin
                    val = refRegs[inst[8:6]] & val;
                end
                refRegs[inst[11:9]] = val;
                setCc(val);
            end
            4'b1001: begin
                val = ~refRegs[inst[8:6]];
                refRegs[inst[11:9]] = val;
                setCc(val);
            end
            4'b0000: begin
                if ((inst[11] & refCc[2]) | (inst[10] & refCc[1]) | (inst[9] & refCc[0])) begin
                    pc = pc + sext(inst, 9);
                end
            end
            4'b1100: pc = refRegs[inst[8:6]];
            // LEA leaves the condition codes alone
            4'b1110: refRegs[inst[11:9]] = pc + sext(inst, 9);
            4'b0010, 4'b0110: begin
                if (inst[15:12] == 4'b0010) begin
                    ea = pc + sext(inst, 9);
                end else begin
                    ea = refRegs[inst[8:6]] + sext(inst, 6);
                end
                val = refMem[ea];
                refRegs[inst[11:9]] = val;
                setCc(val);
            end
            4'b0011, 4'b0111: begin
                if (inst[15:12] == 4'b0011) begin
                    ea = pc + sext(inst, 9);
                end else begin
                    ea = refRegs[inst[8:6]] + sext(inst, 6);
                end
                refMem[ea] = refRegs[inst[11:9]];
                ev.isLed = 1'b0;
                ev.addr = ea;
                ev.data = refRegs[inst[11:9]];
                expQ.push_back(ev);
            end
            4'b1101: begin
                // Only a new value is visible on the LED port
                if (inst[11:0] != refLed) begin
                    ev.isLed = 1'b1;
                    ev.addr = '0;
                    ev.data = {4'b0000, inst[11:0]};
                    expQ.push_back(ev);
                end
                refLed = inst[11:0];
            end
            default: begin
            end
        endcase
    end
    reached = (pc == stopPc);
endtask

`endif

// File: verif/lc3CoreTb.sv
`timescale 1ns/100ps

module lc3CoreTb import lc3IsaPkg::*; ();

    // ----------------------------------------------------------
    // Program layout
    // ----------------------------------------------------------

    localparam word_t resetPc  = 16'h3000;
    localparam int    bodyLen  = 200;
    // Prologue of two words, body, then the halt loop
    localparam int    progLen  = bodyLen + 3;
    localparam word_t haltAddr = resetPc + 16'(progLen - 1);
    localparam word_t dataBase = resetPc + 16'h0100;
    localparam int    dataSize = 64;
    // Worst case of 7 cycles per instruction as all flow is forward
    localparam int    cycleLimit = 7 * progLen + 100;

    logic    Clk;
    logic    arstN;
    word_t   memRdata;
    word_t   memAddr;
    word_t   memWdata;
    logic    memWe;
    ledVal_t led;

    word_t       mem [0:65535];
    logic [31:0] lfsrState;
    ledVal_t     ledPrev;
    logic        running;
    int          cycles;
    int          storeErrors;
    int          ledErrors;
    int          memErrors;
    int          flowErrors;

    `include "lc3RefModel.svh"

    lc3Core #(
        .resetPc (resetPc)
    ) lc3Core_inst (
        .Clk      (Clk),
        .arstN    (arstN),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .led      (led)
    );

    initial begin
        Clk = 1'b0;
    end

    always #20 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
    end

    // Memory with asynchronous read and a write on the rising edge
    assign memRdata = mem[memAddr];

    always @(posedge Clk) begin
        if (memWe) begin
            mem[memAddr] <= memWdata;
        end
    end

    // ----------------------------------------------------------
    // Random program generation
    // ----------------------------------------------------------

    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic word_t drawBits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], stepLfsr()};
        end
        return v;
    endfunction

    // R6 holds jump targets and R7 the data base
    function automatic regIdx_t destReg();
        regIdx_t r;
        r = regIdx_t'(drawBits(3));
        if (r > 3'd5) begin
            r = r - 3'd4;
        end
        return r;
    endfunction

    // PC-relative offset into the data region within 9-bit reach
    function automatic logic [8:0] pcRelOff(input word_t addr);
        int minDiff;
        int room;
        int k;
        minDiff = int'(dataBase) - int'(addr) - 1;
        room = 255 - minDiff;
        k = int'(drawBits(6));
        if (k > room) begin
            k = k % (room + 1);
        end
        return 9'(minDiff + k);
    endfunction

    function automatic word_t randomInst(input word_t addr, input logic [3:0] kind);
        word_t      inst;
        regIdx_t    dst;
        regIdx_t    src;
        logic       useImm;
        logic [2:0] nzp;
        logic [3:0] op;
        dst = destReg();
        src = regIdx_t'(drawBits(3));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                op = (kind < 4'd3) ? 4'b0001 : 4'b0101;
                useImm = 1'(drawBits(1));
                if (useImm) begin
                    inst = {op, dst, src, 1'b1, 5'(drawBits(5))};
                end else begin
                    inst = {op, dst, src, 3'b000, 3'(drawBits(3))};
                end
            end
            4'd5: inst = {4'b1001, dst, src, 6'h3F};
            4'd6, 4'd7: begin
                // Short forward branch with its target fixed up later
                nzp = 3'(drawBits(3));
                inst = {4'b0000, nzp, 9'(drawBits(3))};
            end
            4'd8: inst = {4'b0010, dst, pcRelOff(addr)};
            4'd9, 4'd10: inst = {4'b0011, src, pcRelOff(addr)};
            4'd11: inst = {4'b0110, dst, 3'd7, 1'b0, 5'(drawBits(5))};
            4'd12, 4'd13: inst = {4'b0111, src, 3'd7, 1'b0, 5'(drawBits(5))};
            default: inst = {4'b1101, 12'(drawBits(12))};
        endcase
        return inst;
    endfunction

    // Never past the halt loop and never onto a JMP whose LEA was skipped
    function automatic word_t safeTarget(input word_t target);
        word_t t;
        t = target;
        while (t > haltAddr || mem[t][15:12] == 4'b1100) begin
            t = t - 16'd1;
        end
        return t;
    endfunction

    task automatic fixTargets();
        word_t inst;
        word_t target;
        for (word_t addr = resetPc + 16'd2; addr < haltAddr; addr++) begin
            inst = mem[addr];
            if (inst[15:12] == 4'b0000) begin
                target = safeTarget(addr + 16'd1 + word_t'(inst[8:0]));
                mem[addr] = {inst[15:9], 9'(target - addr - 16'd1)};
            end else if (inst[15:12] == 4'b1110 && inst[11:9] == 3'd6) begin
                target = safeTarget(addr + 16'd2 + word_t'(inst[8:0]));
                mem[addr] = {inst[15:9], 9'(target - addr - 16'd1)};
            end
        end
    endtask

    task automatic buildProgram();
        word_t      addr;
        logic [3:0] kind;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = '0;
        end
        // LEA R7 to the data base then AND R0 so CC is never zero
        mem[resetPc] = {4'b1110, 3'd7, 9'(dataBase - resetPc - 16'd1)};
        mem[resetPc + 16'd1] = {4'b0101, 3'd0, 3'd0, 1'b1, 5'd0};
        addr = resetPc + 16'd2;
        while (addr < haltAddr) begin
            kind = 4'(drawBits(4));
            if (kind == 4'd15 && addr + 16'd1 < haltAddr) begin
                // LEA R6 then JMP R6 with the skip count held in the offset for now
                mem[addr] = {4'b1110, 3'd6, 9'(drawBits(3))};
                mem[addr + 16'd1] = {4'b1100, 3'd0, 3'd6, 6'd0};
                addr = addr + 16'd2;
            end else begin
                mem[addr] = randomInst(addr, kind);
                addr = addr + 16'd1;
            end
        end
        mem[haltAddr] = 16'h0FFF;
        fixTargets();
        for (int k = 0; k < dataSize; k++) begin
            mem[dataBase + 16'(k)] = drawBits(16);
        end
    endtask

    // ----------------------------------------------------------
    // Checkers
    // ----------------------------------------------------------

    task automatic checkStore();
        expEvent_t ev;
        if (expQ.size() == 0 || expQ[0].isLed) begin
            $display("store of %h to %h where the model has no store next", memWdata, memAddr);
            flowErrors++;
        end else begin
            ev = expQ.pop_front();
            if (memAddr !== ev.addr) begin
                $display("error store address: expected %h, actual %h", ev.addr, memAddr);
                storeErrors++;
            end
            if (memWdata !== ev.data) begin
                $display("error store data: expected %h, actual %h", ev.data, memWdata);
                storeErrors++;
            end
        end
    endtask

    task automatic checkLed();
        expEvent_t ev;
        if (expQ.size() == 0 || !expQ[0].isLed) begin
            $display("LED changed to %h where the model has no LED change next", led);
            flowErrors++;
        end else begin
            ev = expQ.pop_front();
            if (led !== ev.data[11:0]) begin
                $display("error led value: expected %h, actual %h", ev.data[11:0], led);
                ledErrors++;
            end
        end
    endtask

    task automatic compareData();
        word_t a;
        for (int k = 0; k < dataSize; k++) begin
            a = dataBase + 16'(k);
            if (mem[a] !== refMem[a]) begin
                $display("error data memory at %h: expected %h, actual %h", a, refMem[a], mem[a]);
                memErrors++;
            end
        end
    endtask

    task automatic reportCounts();
        $display("Error counts: store %0d, led %0d, data memory %0d, flow %0d",
                 storeErrors, ledErrors, memErrors, flowErrors);
    endtask

    // Outputs sampled on the falling edge
    always @(negedge Clk) begin
        if (running) begin
            if (memWe) begin
                checkStore();
            end
            if (led !== ledPrev) begin
                checkLed();
            end
            ledPrev <= led;
        end
    end

    // ----------------------------------------------------------
    // Main sequence and timeout
    // ----------------------------------------------------------

    initial begin
        bit modelDone;
        arstN = 1'b0;
        running = 1'b0;
        ledPrev = '0;
        cycles = 0;
        storeErrors = 0;
        ledErrors = 0;
        memErrors = 0;
        flowErrors = 0;
        lfsrState = 32'h68e9;
        buildProgram();
        refMem = mem;
        runModel(resetPc, haltAddr, modelDone);
        if (!modelDone) begin
            $display("the model did not reach the halt address");
            flowErrors++;
        end
        repeat (2) @(posedge Clk);
        arstN <= 1'b1;
        running = 1'b1;
        @(negedge Clk);
        if (led !== '0) begin
            $display("error led after reset: expected %h, actual %h", 12'h000, led);
            ledErrors++;
        end
        while (memAddr !== haltAddr) begin
            @(negedge Clk);
        end
        if (expQ.size() != 0) begin
            $display("%0d stores or LED changes of the model never happened", expQ.size());
            flowErrors++;
        end
        compareData();
        reportCounts();
        if (storeErrors + ledErrors + memErrors + flowErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (cycles >= cycleLimit);
        $display("timeout: the core did not reach the halt loop in %0d cycles", cycleLimit);
        reportCounts();
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog/lc3Core.sv
`timescale 1ns/100ps

module lc3Core import lc3IsaPkg::*, lc3CtrlPkg::*; #(
    parameter word_t resetPc = 16'h3000
) (
    input  logic    Clk,
    input  logic    arstN,
    input  word_t   memRdata,
    output word_t   memAddr,
    output word_t   memWdata,
    output logic    memWe,
    output ledVal_t led
);

    ctrlWord_t ctrl;
    word_t     ir;
    logic      ben;

    // Write strobe comes straight from the control word
    assign memWe = ctrl.memWe;

    controlUnit controlUnit_inst (
        .Clk   (Clk),
        .arstN (arstN),
        .ir    (ir),
        .ben   (ben),
        .ctrl  (ctrl)
    );

    datapath #(
        .resetPc (resetPc)
    ) datapath_inst (
        .Clk      (Clk),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .ir       (ir),
        .ben      (ben),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .led      (led)
    );

endmodule

// File: verilog/controlUnit.sv
`timescale 1ns/100ps

module controlUnit import lc3IsaPkg::*, lc3CtrlPkg::*; (
    input  logic      Clk,
    input  logic      arstN,
    input  word_t     ir,
    input  logic      ben,
    output ctrlWord_t ctrl
);

    ctrlState_t state;
    ctrlState_t stateNext;
    opcode_t    opcode;
    logic       baseOffset;

    assign opcode     = opcode_t'(ir[15:12]);
    // LDR and STR address from a base register
    assign baseOffset = (opcode == opLdr) || (opcode == opStr);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= sFetch1;
        end else begin
            state <= stateNext;
        end
    end

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------

    always_comb begin
        stateNext = sFetch1;
        case (state)
            sFetch1: stateNext = sFetch2;
            sFetch2: stateNext = sFetch3;
            sFetch3: stateNext = sDecode;
            sDecode: begin
                case (opcode)
                    opAdd, opAnd, opNot: stateNext = sAluOp;
                    opBr:                stateNext = sBr;
                    opJmp:               stateNext = sJmp;
                    opLea:               stateNext = sLea;
                    opPse:               stateNext = sPse;
                    opLd, opLdr:         stateNext = sLdMar;
                    opSt, opStr:         stateNext = sStMar;
                    default:             stateNext = sFetch1;
                endcase
            end
            sLdMar:  stateNext = sLdMdr;
            sLdMdr:  stateNext = sLdReg;
            sStMar:  stateNext = sStMdr;
            sStMdr:  stateNext = sStWrite;
            default: stateNext = sFetch1;
        endcase
    end

    // ----------------------------------------------------------
    // Control word
    // ----------------------------------------------------------

    always_comb begin
        // All strobes off, first entry of every select
        ctrl = '0;
        case (state)
            sFetch1: begin
                ctrl.busSel = busPc;
                ctrl.ldMar  = 1'b1;
                ctrl.pcSel  = pcPlus1;
                ctrl.ldPc   = 1'b1;
            end
            sFetch2: begin
                ctrl.mdrSel = mdrMemory;
                ctrl.ldMdr  = 1'b1;
            end
            sFetch3: begin
                ctrl.busSel = busMdr;
                ctrl.ldIr   = 1'b1;
            end
            sDecode: begin
                ctrl.ldBen = 1'b1;
            end
            sAluOp: begin
                ctrl.sr1Sel = sr1Ir8to6;
                ctrl.sr2Sel = ir[5] ? sr2ImmSext : sr2RegOut;
                case (opcode)
                    opAnd:   ctrl.aluOp = aluAnd;
                    opNot:   ctrl.aluOp = aluNot;
                    default: ctrl.aluOp = aluAdd;
                endcase
                ctrl.busSel = busAlu;
                ctrl.drSel  = drIr11to9;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
            end
            sLea: begin
                ctrl.addr1Sel = addr1Pc;
                ctrl.addr2Sel = addr2Off9;
                ctrl.busSel   = busMarMux;
                ctrl.drSel    = drIr11to9;
                ctrl.ldReg    = 1'b1;
            end
            sBr: begin
                // PC moves only for a taken branch
                ctrl.addr1Sel = addr1Pc;
                ctrl.addr2Sel = addr2Off9;
                ctrl.pcSel    = pcAddrSum;
                ctrl.ldPc     = ben;
            end
            sJmp: begin
                ctrl.sr1Sel   = sr1Ir8to6;
                ctrl.addr1Sel = addr1Sr1;
                ctrl.addr2Sel = addr2Zero;
                ctrl.pcSel    = pcAddrSum;
                ctrl.ldPc     = 1'b1;
            end
            sPse: begin
                ctrl.ldLed = 1'b1;
            end
            sLdMar, sStMar: begin
                ctrl.sr1Sel   = sr1Ir8to6;
                ctrl.addr1Sel = baseOffset ? addr1Sr1 : addr1Pc;
                ctrl.addr2Sel = baseOffset ? addr2Off6 : addr2Off9;
                ctrl.busSel   = busMarMux;
                ctrl.ldMar    = 1'b1;
            end
            sLdMdr: begin
                ctrl.mdrSel = mdrMemory;
                ctrl.ldMdr  = 1'b1;
            end
            sLdReg: begin
                ctrl.busSel = busMdr;
                ctrl.drSel  = drIr11to9;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
            end
            sStMdr: begin
                // Store source register through the ALU
                ctrl.sr1Sel = sr1Ir11to9;
                ctrl.aluOp  = aluPassA;
                ctrl.busSel = busAlu;
                ctrl.mdrSel = mdrBus;
                ctrl.ldMdr  = 1'b1;
            end
            sStWrite: begin
                ctrl.memWe = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/100ps

module datapath import lc3IsaPkg::*, lc3CtrlPkg::*; #(
    parameter word_t resetPc = 16'h3000
) (
    input  logic      Clk,
    input  logic      arstN,
    input  ctrlWord_t ctrl,
    input  word_t     memRdata,
    output word_t     ir,
    output logic      ben,
    output word_t     memAddr,
    output word_t     memWdata,
    output ledVal_t   led
);

    // ----------------------------------------------------------
    // Signals
    // ----------------------------------------------------------

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } cc_t;

    word_t pc;
    word_t mar;
    word_t mdr;
    cc_t   cc;

    word_t mainBus;
    word_t pcNext;
    word_t mdrNext;

    // Address adder
    word_t addr1;
    word_t addr2;
    word_t addrSum;

    // Sign-extended IR fields
    word_t imm5Sext;
    word_t off6Sext;
    word_t off9Sext;
    word_t off11Sext;

    regIdx_t drIdx;
    regIdx_t sr1Idx;
    word_t   sr1Out;
    word_t   sr2Out;
    word_t   aluB;
    word_t   aluOut;

    assign imm5Sext  = {{(wordW-imm5W){ir[imm5W-1]}}, ir[imm5W-1:0]};
    assign off6Sext  = {{(wordW-off6W){ir[off6W-1]}}, ir[off6W-1:0]};
    assign off9Sext  = {{(wordW-off9W){ir[off9W-1]}}, ir[off9W-1:0]};
    assign off11Sext = {{(wordW-off11W){ir[off11W-1]}}, ir[off11W-1:0]};

    assign memAddr  = mar;
    assign memWdata = mdr;

    // ----------------------------------------------------------
    // Register file and ALU
    // ----------------------------------------------------------

    regFile regFile_inst (
        .Clk    (Clk),
        .arstN  (arstN),
        .ld     (ctrl.ldReg),
        .dr     (drIdx),
        .sr1    (sr1Idx),
        .sr2    (ir[2:0]),
        .din    (mainBus),
        .sr1Out (sr1Out),
        .sr2Out (sr2Out)
    );

    alu alu_inst (
        .a  (sr1Out),
        .b  (aluB),
        .op (ctrl.aluOp),
        .y  (aluOut)
    );

    // ----------------------------------------------------------
    // Muxes
    // ----------------------------------------------------------

    assign addr1   = (ctrl.addr1Sel == addr1Pc) ? pc : sr1Out;
    assign addrSum = addr1 + addr2;

    always_comb begin
        case (ctrl.addr2Sel)
            addr2Off6:  addr2 = off6Sext;
            addr2Off9:  addr2 = off9Sext;
            addr2Off11: addr2 = off11Sext;
            default:    addr2 = '0;
        endcase
    end

    // One source at a time, anything else leaves the bus at zero
    always_comb begin
        case (ctrl.busSel)
            busPc:     mainBus = pc;
            busMdr:    mainBus = mdr;
            busAlu:    mainBus = aluOut;
            busMarMux: mainBus = addrSum;
            default:   mainBus = '0;
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            pcAddrSum: pcNext = addrSum;
            pcDataBus: pcNext = mainBus;
            default:   pcNext = pc + 16'd1;
        endcase
    end

    assign sr1Idx  = (ctrl.sr1Sel == sr1Ir11to9) ? ir[11:9] : ir[8:6];
    assign drIdx   = (ctrl.drSel == drR7) ? 3'd7 : ir[11:9];
    assign aluB    = (ctrl.sr2Sel == sr2ImmSext) ? imm5Sext : sr2Out;
    assign mdrNext = (ctrl.mdrSel == mdrMemory) ? memRdata : mainBus;

    // ----------------------------------------------------------
    // Processor registers
    // ----------------------------------------------------------

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc  <= resetPc;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            cc  <= '0;
            ben <= 1'b0;
            led <= '0;
        end else begin
            if (ctrl.ldPc) begin
                pc <= pcNext;
            end
            if (ctrl.ldIr) begin
                ir <= mainBus;
            end
            if (ctrl.ldMar) begin
                mar <= mainBus;
            end
            if (ctrl.ldMdr) begin
                mdr <= mdrNext;
            end
            // Sign of the bus value
            if (ctrl.ldCc) begin
                cc.n <= mainBus[wordW-1];
                cc.z <= (mainBus == '0);
                cc.p <= !mainBus[wordW-1] && (mainBus != '0);
            end
            if (ctrl.ldBen) begin
                ben <= (ir[11] & cc.n) | (ir[10] & cc.z) | (ir[9] & cc.p);
            end
            if (ctrl.ldLed) begin
                led <= ir[ledW-1:0];
            end
        end
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/100ps

module alu import lc3IsaPkg::*, lc3CtrlPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  y
);

    always_comb begin
        case (op)
            aluAdd: begin
                y = a + b;
            end
            aluAnd: begin
                y = a & b;
            end
            aluNot: begin
                y = ~a;
            end
            default: begin
                // Pass A, used to move a source register into MDR
                y = a;
            end
        endcase
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/100ps

module regFile import lc3IsaPkg::*; (
    input  logic    Clk,
    input  logic    arstN,
    input  logic    ld,
    input  regIdx_t dr,
    input  regIdx_t sr1,
    input  regIdx_t sr2,
    input  word_t   din,
    output word_t   sr1Out,
    output word_t   sr2Out
);

    word_t regs [regCount];

    // Single write port
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ld) begin
            regs[dr] <= din;
        end
    end

    // Asynchronous read ports
    assign sr1Out = regs[sr1];
    assign sr2Out = regs[sr2];

endmodule

// File: verilog/lc3CtrlPkg.sv
package lc3CtrlPkg;

    // ----------------------------------------------------------
    // Datapath mux selects
    // ----------------------------------------------------------

    typedef enum logic [1:0] {pcPlus1, pcAddrSum, pcDataBus} pcSel_t;

    typedef enum logic {addr1Sr1, addr1Pc} addr1Sel_t;

    typedef enum logic [1:0] {addr2Zero, addr2Off6, addr2Off9, addr2Off11} addr2Sel_t;

    typedef enum logic {sr1Ir8to6, sr1Ir11to9} sr1Sel_t;

    typedef enum logic {sr2RegOut, sr2ImmSext} sr2Sel_t;

    typedef enum logic {drIr11to9, drR7} drSel_t;

    typedef enum logic {mdrBus, mdrMemory} mdrSel_t;

    typedef enum logic [1:0] {aluAdd, aluAnd, aluNot, aluPassA} aluOp_t;

    // Source driving the main bus
    typedef enum logic [2:0] {busNone, busPc, busMdr, busAlu, busMarMux} busSel_t;

    // ----------------------------------------------------------
    // Control word, one per control state
    // ----------------------------------------------------------

    typedef struct packed {
        logic      ldMar;
        logic      ldMdr;
        logic      ldIr;
        logic      ldBen;
        logic      ldCc;
        logic      ldReg;
        logic      ldPc;
        logic      ldLed;
        busSel_t   busSel;
        pcSel_t    pcSel;
        addr1Sel_t addr1Sel;
        addr2Sel_t addr2Sel;
        sr1Sel_t   sr1Sel;
        sr2Sel_t   sr2Sel;
        drSel_t    drSel;
        mdrSel_t   mdrSel;
        aluOp_t    aluOp;
        logic      memWe;
    } ctrlWord_t;

    typedef enum logic [3:0] {
        sFetch1, sFetch2, sFetch3, sDecode,
        sAluOp, sLea, sBr, sJmp, sPse,
        sLdMar, sLdMdr, sLdReg,
        sStMar, sStMdr, sStWrite
    } ctrlState_t;

endpackage

// File: verilog/lc3IsaPkg.sv
package lc3IsaPkg;

    // ----------------------------------------------------------
    // Machine widths
    // ----------------------------------------------------------

    localparam int wordW    = 16;
    localparam int regIdxW  = 3;
    localparam int regCount = 8;
    localparam int ledW     = 12;

    // Instruction field widths
    localparam int opcodeW = 4;
    localparam int imm5W   = 5;
    localparam int off6W   = 6;
    localparam int off9W   = 9;
    localparam int off11W  = 11;

    typedef logic [wordW-1:0]   word_t;
    typedef logic [regIdxW-1:0] regIdx_t;
    typedef logic [ledW-1:0]    ledVal_t;

    // ----------------------------------------------------------
    // Opcodes, IR[15:12]
    // ----------------------------------------------------------

    typedef enum logic [opcodeW-1:0] {
        opBr  = 4'b0000,
        opAdd = 4'b0001,
        opLd  = 4'b0010,
        opSt  = 4'b0011,
        opAnd = 4'b0101,
        opLdr = 4'b0110,
        opStr = 4'b0111,
        opNot = 4'b1001,
        opJmp = 4'b1100,
        opPse = 4'b1101,
        opLea = 4'b1110
    } opcode_t;

endpackage
